// ==== bench/raven_io_asserts.sv ====
// Bus handshake and pad masking assertions for raven_io
`default_nettype none

module raven_io_asserts import raven_io_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input logic       clk,
	input logic       resetn,
	input bus_req_t   req,
	input logic       mem_ready,
	input route_cfg_t cfg,
	input pad_out_t   pads
);

	// Number of failed assertions
	int   fail_count = 0;
	logic mapped;
	logic mask_ok;

	// Access that lands in the RAM window or the I/O page
	assign mapped = req.valid && (({req.addr.ram.upper, req.addr.ram.word_idx} < MEM_WORDS)
		|| (req.addr.io.page == IO_PAGE));

	// Routed groups drive no direction bits
	assign mask_ok = ((cfg.comp_dest == 2'd0) || (pads.gpio_outenb[1:0] == 2'b00))
		&& ((cfg.rcosc_dest == 2'd0) || (pads.gpio_outenb[4:2] == 3'b000))
		&& ((cfg.xtal_dest == 2'd0) || (pads.gpio_outenb[7:5] == 3'b000))
		&& ((cfg.trap_dest == 2'd0) || (pads.gpio_outenb[13:11] == 3'b000))
		&& ((cfg.overtemp_dest == 2'd0) || (pads.gpio_outenb[15:14] == 2'b00));

	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |=> !mem_ready)
		else begin
			$error("mem_ready high for two cycles");
			fail_count++;
		end

	a_ready_follows: assert property (@(posedge clk) disable iff (!resetn)
		mapped && !mem_ready |=> mem_ready)
		else begin
			$error("mapped access not answered on the next cycle");
			fail_count++;
		end

	a_dir_mask: assert property (@(posedge clk) disable iff (!resetn) mask_ok)
		else begin
			$error("routed group left direction bits set");
			fail_count++;
		end

endmodule

bind raven_io raven_io_asserts #(.MEM_WORDS(MEM_WORDS)) u_asserts (
	.clk       (clk),
	.resetn    (resetn),
	.req       (req),
	.mem_ready (mem_ready),
	.cfg       (cfg),
	.pads      (pads)
);

`default_nettype wire

// ==== bench/raven_io_tb.sv ====
// Directed testbench for raven_io
// Bus master, SRAM model, register shadows and watchdog
`default_nettype none

module raven_io_tb import raven_io_pkg::*;;

	localparam int MEM_WORDS = 1024;
	// Upper bound on bus accesses over all tests
	localparam int N_ACCESS = 256;

	logic         clk;
	logic         resetn;
	bus_req_t     req;
	word_t        ram_rdata;
	analog_stat_t stat;
	logic         trap;
	logic [15:0]  gpio_in;
	logic         irq_pin;
	logic         irq_spi;
	logic         mem_ready;
	word_t        mem_rdata;
	logic         ram_wenb;
	logic [9:0]   ram_addr;
	word_t        ram_wdata;
	analog_ctrl_t actl;
	pad_out_t     pads;
	word_t        irq;

	int           errors = 0;
	int           seed = 32'haa9e2826;
	word_t        sram [0:MEM_WORDS-1];
	// Shadows of the written registers
	logic [15:0]  sh_gpio, sh_oeb, sh_pu, sh_pd;
	analog_ctrl_t exp_actl;

	raven_io #(.MEM_WORDS(MEM_WORDS)) UUT (
		.clk(clk), .resetn(resetn), .req(req), .ram_rdata(ram_rdata), .stat(stat),
		.trap(trap), .gpio_in(gpio_in), .irq_pin(irq_pin), .irq_spi(irq_spi),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .ram_wenb(ram_wenb),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .actl(actl), .pads(pads), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// SRAM with registered read data
	always @(posedge clk) begin
		if (!ram_wenb)
			sram[ram_addr] <= ram_wdata;
		ram_rdata <= sram[ram_addr];
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_pads(input string name, input pad_out_t exp, input pad_out_t act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_actl(input string name, input analog_ctrl_t exp,
		input analog_ctrl_t act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_irq(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// One access, entered and left one unit after a rising edge
	task automatic bus_access(input word_t addr, input word_t wd, input strb_t st,
		output word_t rd);
		int cyc;
		cyc = 0;
		req.valid = 1'b1;
		req.addr  = addr;
		req.wdata = wd;
		req.wstrb = st;
		do begin
			@(negedge clk);
			cyc++;
		end while (!mem_ready);
		rd = mem_rdata;
		@(posedge clk);
		#1;
		req = '0;
		// Ready shows at the second falling edge
		check_word("ready latency", 32'd2, word_t'(cyc));
	endtask

	task automatic bus_write(input word_t addr, input word_t wd, input strb_t st);
		word_t dummy;
		bus_access(addr, wd, st, dummy);
	endtask

	task automatic bus_read(input word_t addr, output word_t rd);
		bus_access(addr, '0, 4'h0, rd);
	endtask

	function automatic word_t io_addr(input logic [7:0] off);
		return {IO_PAGE, off};
	endfunction

	// Byte lanes selected by a strobe
	function automatic word_t lane_mask(input strb_t st);
		return {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
	endfunction

	task automatic reset_values();
		logic [7:0] offs [$] = '{REG_GPIO_DATA, REG_GPIO_PU, REG_GPIO_PD, REG_ADC0_ENA,
			REG_ADC0_CONVERT, REG_ADC0_INPUTSRC, REG_ADC1_ENA, REG_ADC1_CONVERT,
			REG_ADC1_INPUTSRC, REG_DAC_ENA, REG_DAC_VALUE, REG_COMP_ENA,
			REG_COMP_NINPUTSRC, REG_COMP_PINPUTSRC, REG_COMP_DEST, REG_RCOSC_ENA,
			REG_RCOSC_DEST, REG_XTAL_DEST, REG_TRAP_DEST, REG_IRQ7_SRC, REG_IRQ8_SRC,
			REG_ANALOG_OUT_SEL, REG_OPAMP_BIAS_ENA, REG_OPAMP_ENA, REG_BG_ENA,
			REG_OVERTEMP_ENA, REG_OVERTEMP_DEST};
		word_t rd;
		check_actl("reset actl", '0, actl);
		check_pads("reset pads", {16'h0000, 16'hffff, 16'h0000, 16'h0000}, pads);
		check_word("reset ready", 32'd0, word_t'(mem_ready));
		check_word("reset wenb", 32'd1, word_t'(ram_wenb));
		check_irq("reset irq", '0, irq);
		bus_read(io_addr(REG_GPIO_OEB), rd);
		check_word("reset oeb", 32'h0000ffff, rd);
		foreach (offs[i]) begin
			bus_read(io_addr(offs[i]), rd);
			check_word($sformatf("reset reg %h", offs[i]), '0, rd);
		end
	endtask

	// GPIO data, DAC value and the four analog source selects
	task automatic strobed_writes();
		logic [7:0] offs [6] = '{REG_GPIO_DATA, REG_DAC_VALUE, REG_ADC0_INPUTSRC,
			REG_ADC1_INPUTSRC, REG_COMP_NINPUTSRC, REG_COMP_PINPUTSRC};
		word_t widths [6] = '{32'hffff, 32'h3ff, 32'h3, 32'h3, 32'h3, 32'h3};
		word_t shadow [6] = '{0, 0, 0, 0, 0, 0};
		word_t wd, rd, exp;
		strb_t st;
		for (int it = 0; it < 6; it++) begin
			for (int r = 0; r < 6; r++) begin
				wd = $random(seed);
				st = strb_t'($random(seed));
				shadow[r] = ((shadow[r] & ~lane_mask(st)) | (wd & lane_mask(st))) & widths[r];
				bus_write(io_addr(offs[r]), wd, st);
				bus_read(io_addr(offs[r]), rd);
				// GPIO data reads pad value over input pins, inputs held at 0
				exp = (r == 0) ? {shadow[0][15:0], 16'h0} : shadow[r];
				check_word($sformatf("strobe reg %h", offs[r]), exp, rd);
			end
			exp_actl.dac_value      = shadow[1][9:0];
			exp_actl.adc0_inputsrc  = shadow[2][1:0];
			exp_actl.adc1_inputsrc  = shadow[3][1:0];
			exp_actl.comp_ninputsrc = shadow[4][1:0];
			exp_actl.comp_pinputsrc = shadow[5][1:0];
			check_actl("strobe actl", exp_actl, actl);
		end
		sh_gpio = shadow[0][15:0];
	endtask

	// Single-bit controls, upper bits of the write are dropped
	task automatic enable_bits();
		logic [7:0] offs [$] = '{REG_ADC0_ENA, REG_ADC0_CONVERT, REG_ADC1_ENA,
			REG_ADC1_CONVERT, REG_DAC_ENA, REG_COMP_ENA, REG_RCOSC_ENA,
			REG_ANALOG_OUT_SEL, REG_OPAMP_BIAS_ENA, REG_OPAMP_ENA, REG_BG_ENA,
			REG_OVERTEMP_ENA};
		word_t rd;
		foreach (offs[i]) begin
			bus_write(io_addr(offs[i]), 32'hffffffff, 4'h1);
			bus_read(io_addr(offs[i]), rd);
			check_word($sformatf("enable reg %h", offs[i]), 32'd1, rd);
		end
		exp_actl.adc0_ena       = 1'b1;
		exp_actl.adc0_convert   = 1'b1;
		exp_actl.adc1_ena       = 1'b1;
		exp_actl.adc1_convert   = 1'b1;
		exp_actl.dac_ena        = 1'b1;
		exp_actl.comp_ena       = 1'b1;
		exp_actl.rcosc_ena      = 1'b1;
		exp_actl.analog_out_sel = 1'b1;
		exp_actl.opamp_bias_ena = 1'b1;
		exp_actl.opamp_ena      = 1'b1;
		exp_actl.bg_ena         = 1'b1;
		exp_actl.overtemp_ena   = 1'b1;
		check_actl("enable actl", exp_actl, actl);
	endtask

	task automatic ram_window();
		word_t wd, rd;
		logic [9:0] idx;
		for (int i = 0; i < 8; i++) begin
			idx = 10'($random(seed));
			wd  = $random(seed);
			bus_write({20'h0, idx, 2'b00}, wd, 4'hf);
			check_word("ram store", wd, sram[idx]);
			bus_read({20'h0, idx, 2'b00}, rd);
			check_word("ram readback", wd, rd);
			// A read without strobes leaves the word in place
			check_word("ram after read", wd, sram[idx]);
		end
	endtask

	function automatic pad_out_t expected_pads(input int g, input logic [1:0] dest,
		input logic live);
		int base [5] = '{0, 2, 5, 11, 14};
		int npin [5] = '{2, 3, 3, 3, 2};
		pad_out_t p;
		p = {sh_gpio, sh_oeb, sh_pu, sh_pd};
		if (dest != 2'd0 && int'(dest) <= npin[g])
			p.gpio_out[base[g] + int'(dest) - 1] = live;
		if (dest != 2'd0) begin
			for (int k = 0; k < npin[g]; k++) begin
				p.gpio_outenb[base[g] + k]   = 1'b0;
				p.gpio_pullup[base[g] + k]   = 1'b0;
				p.gpio_pulldown[base[g] + k] = 1'b0;
			end
		end
		return p;
	endfunction

	task automatic drive_live(input int g, input logic v);
		case (g)
			0: stat.comp_in = v;
			1: stat.rcosc_in = v;
			2: stat.xtal_in = v;
			3: trap = v;
			default: stat.overtemp = v;
		endcase
	endtask

	task automatic pad_routing();
		logic [7:0] dregs [5] = '{REG_COMP_DEST, REG_RCOSC_DEST, REG_XTAL_DEST,
			REG_TRAP_DEST, REG_OVERTEMP_DEST};
		sh_oeb = 16'hffff;
		sh_pu  = 16'($random(seed));
		sh_pd  = 16'($random(seed));
		bus_write(io_addr(REG_GPIO_OEB), 32'(sh_oeb), 4'h3);
		bus_write(io_addr(REG_GPIO_PU), 32'(sh_pu), 4'h3);
		bus_write(io_addr(REG_GPIO_PD), 32'(sh_pd), 4'h3);
		for (int g = 0; g < 5; g++) begin
			for (int d = 0; d < 4; d++) begin
				bus_write(io_addr(dregs[g]), d, 4'h1);
				for (int v = 0; v < 2; v++) begin
					drive_live(g, v[0]);
					@(negedge clk);
					check_pads($sformatf("pads group %0d dest %0d", g, d),
						expected_pads(g, 2'(d), v[0]), pads);
					@(posedge clk);
					#1;
				end
			end
			bus_write(io_addr(dregs[g]), 0, 4'h1);
			drive_live(g, 1'b0);
		end
	endtask

	task automatic interrupt_vector();
		word_t exp;
		for (int s7 = 0; s7 < 4; s7++) begin
			for (int s8 = 0; s8 < 4; s8++) begin
				bus_write(io_addr(REG_IRQ7_SRC), s7, 4'h1);
				bus_write(io_addr(REG_IRQ8_SRC), s8, 4'h1);
				for (int k = 0; k < 6; k++) begin
					gpio_in = 16'($random(seed));
					irq_pin = 1'($random(seed));
					irq_spi = 1'($random(seed));
					exp = '0;
					exp[5] = irq_pin;
					exp[6] = irq_spi;
					exp[7] = (s7 == 0) ? 1'b0 : gpio_in[s7 - 1];
					exp[8] = (s8 == 0) ? 1'b0 : gpio_in[s8 + 2];
					@(negedge clk);
					check_irq($sformatf("irq src %0d %0d", s7, s8), exp, irq);
					@(posedge clk);
					#1;
				end
			end
		end
		gpio_in = '0;
		irq_pin = 1'b0;
		irq_spi = 1'b0;
		// Comparator and over-temperature reach irq only at dest 3
		for (int d = 2; d < 4; d++) begin
			bus_write(io_addr(REG_COMP_DEST), d, 4'h1);
			bus_write(io_addr(REG_OVERTEMP_DEST), d, 4'h1);
			stat.comp_in  = 1'b1;
			stat.overtemp = 1'b1;
			@(negedge clk);
			check_irq($sformatf("irq analog dest %0d", d), (d == 3) ? 32'h600 : 32'h0, irq);
			@(posedge clk);
			#1;
			stat.comp_in  = 1'b0;
			stat.overtemp = 1'b0;
		end
		bus_write(io_addr(REG_COMP_DEST), 0, 4'h1);
		bus_write(io_addr(REG_OVERTEMP_DEST), 0, 4'h1);
		bus_write(io_addr(REG_IRQ7_SRC), 0, 4'h1);
		bus_write(io_addr(REG_IRQ8_SRC), 0, 4'h1);
	endtask

	task automatic status_regs();
		word_t rd;
		stat.adc0_data = 10'($random(seed));
		stat.adc1_data = 10'($random(seed));
		stat.adc0_done = 1'b1;
		stat.adc1_done = 1'b1;
		stat.overtemp  = 1'b1;
		gpio_in        = 16'($random(seed));
		bus_read(io_addr(REG_ADC0_DATA), rd);
		check_word("adc0 data", 32'(stat.adc0_data), rd);
		bus_read(io_addr(REG_ADC1_DATA), rd);
		check_word("adc1 data", 32'(stat.adc1_data), rd);
		bus_read(io_addr(REG_ADC0_DONE), rd);
		check_word("adc0 done", 32'd1, rd);
		bus_read(io_addr(REG_ADC1_DONE), rd);
		check_word("adc1 done", 32'd1, rd);
		bus_read(io_addr(REG_OVERTEMP), rd);
		check_word("overtemp level", 32'd1, rd);
		bus_read(io_addr(REG_GPIO_DATA), rd);
		check_word("gpio data", {sh_gpio, gpio_in}, rd);
		// Read-only and unmapped writes leave state alone
		bus_write(io_addr(REG_ADC0_DATA), 32'hffffffff, 4'hf);
		bus_read(io_addr(REG_ADC0_DATA), rd);
		check_word("adc0 data after write", 32'(stat.adc0_data), rd);
		bus_write(io_addr(8'h80), 32'hffffffff, 4'hf);
		bus_read(io_addr(8'h80), rd);
		check_word("unmapped offset", '0, rd);
		check_actl("status actl", exp_actl, actl);
		check_pads("status pads", {sh_gpio, sh_oeb, sh_pu, sh_pd}, pads);
		check_irq("status irq", '0, irq);
		// Outside both windows, no answer expected
		req.valid = 1'b1;
		req.addr  = 32'h1000_0000;
		repeat (4) begin
			@(negedge clk);
			if (mem_ready) begin
				$display("Access outside both windows was acknowledged");
				errors++;
			end
		end
		@(posedge clk);
		#1;
		req = '0;
	endtask

	// Watchdog sized from the access count
	initial begin
		repeat (N_ACCESS * 10 + 200) @(posedge clk);
		$display("Bus hung, run stopped by the watchdog");
		$display("Errors found");
		$finish;
	end

	initial begin
		resetn    = 1'b0;
		req       = '0;
		stat      = '0;
		trap      = 1'b0;
		gpio_in   = '0;
		irq_pin   = 1'b0;
		irq_spi   = 1'b0;
		ram_rdata = '0;
		exp_actl  = '0;
		// Fill pattern tied to every address bit
		for (int i = 0; i < MEM_WORDS; i++)
			sram[i] = {16'(i) ^ 16'h5a5a, ~16'(i)};
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		@(posedge clk);
		#1;
		reset_values();
		strobed_writes();
		enable_bits();
		ram_window();
		pad_routing();
		interrupt_vector();
		status_regs();
		repeat (2) @(posedge clk);
		$display("Done: %0d check errors, %0d assertion failures", errors,
			UUT.u_asserts.fail_count);
		if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== raven_io.f ====
source/raven_io_pkg.sv
source/bus_decode.sv
source/io_reg_bank.sv
source/pin_mux.sv
source/raven_io.sv
bench/raven_io_asserts.sv
bench/raven_io_tb.sv

// ==== source/bus_decode.sv ====
// Address decode for the memory bus
// Splits accesses between SRAM window and I/O page, merges the response
`default_nettype none

module bus_decode import raven_io_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input  logic        clk,
	input  logic        resetn,
	input  bus_req_t    req,
	input  logic        io_ready,
	input  word_t       io_rdata,
	input  word_t       ram_rdata,
	output io_req_t     io_req,
	output logic        ram_wenb,
	output logic [9:0]  ram_addr,
	output word_t       ram_wdata,
	output logic        mem_ready,
	output word_t       mem_rdata
);

	logic in_ram;
	logic ram_first;
	logic ram_ready;

	// Word address below MEM_WORDS, byte offset ignored
	assign in_ram = {req.addr.ram.upper, req.addr.ram.word_idx} < MEM_WORDS;

	// First cycle of an SRAM access only
	// ram_ready blocks a second strobe while the master still holds valid
	assign ram_first = req.valid && in_ram && !ram_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ram_ready <= 1'b0;
		end else begin
			ram_ready <= ram_first;
		end
	end

	// SRAM port
	// Write enable is active low and needs at least one strobe
	assign ram_wenb  = ram_first ? ~(|req.wstrb) : 1'b1;
	assign ram_addr  = req.addr.ram.word_idx;
	assign ram_wdata = req.wdata;

	// Register bank request, page compare through the I/O view
	assign io_req.sel    = req.valid && (req.addr.io.page == IO_PAGE);
	assign io_req.offset = req.addr.io.offset;
	assign io_req.wdata  = req.wdata;
	assign io_req.wstrb  = req.wstrb;

	// Response merge
	// Windows never overlap, so at most one source is ready
	assign mem_ready = ram_ready || io_ready;

	always_comb begin
		if (io_ready) begin
			mem_rdata = io_rdata;
		end else if (ram_ready) begin
			mem_rdata = ram_rdata;
		end else begin
			mem_rdata = '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/io_reg_bank.sv ====
// I/O control register bank
// Byte-strobed writes, registered read data, single-cycle acknowledge
`default_nettype none

module io_reg_bank import raven_io_pkg::*; (
	input  logic         clk,
	input  logic         resetn,
	input  io_req_t      io_req,
	input  analog_stat_t stat,
	input  logic [15:0]  gpio_out,
	input  logic [15:0]  gpio_in,
	output logic         io_ready,
	output word_t        io_rdata,
	output route_cfg_t   cfg,
	output analog_ctrl_t actl
);

	logic  ack;
	word_t rd_word;

	// Old value with strobed bytes replaced
	// Callers truncate to the field width
	function automatic word_t bmerge(input word_t old, input io_req_t r);
		word_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (r.wstrb[b])
				res[8*b +: 8] = r.wdata[8*b +: 8];
		end
		return res;
	endfunction

	// One acknowledge per access, master holds sel through the ready cycle
	assign ack = io_req.sel && !io_ready;

	// Read mux, unmapped offsets return zero
	always_comb begin
		rd_word = '0;
		case (io_req.offset)
			REG_GPIO_DATA:      rd_word = {gpio_out, gpio_in};
			REG_GPIO_OEB:       rd_word[15:0] = cfg.gpio_oeb;
			REG_GPIO_PU:        rd_word[15:0] = cfg.gpio_pu;
			REG_GPIO_PD:        rd_word[15:0] = cfg.gpio_pd;
			REG_ADC0_ENA:       rd_word[0] = actl.adc0_ena;
			REG_ADC0_DATA:      rd_word[9:0] = stat.adc0_data;
			REG_ADC0_DONE:      rd_word[0] = stat.adc0_done;
			REG_ADC0_CONVERT:   rd_word[0] = actl.adc0_convert;
			REG_ADC0_INPUTSRC:  rd_word[1:0] = actl.adc0_inputsrc;
			REG_ADC1_ENA:       rd_word[0] = actl.adc1_ena;
			REG_ADC1_DATA:      rd_word[9:0] = stat.adc1_data;
			REG_ADC1_DONE:      rd_word[0] = stat.adc1_done;
			REG_ADC1_CONVERT:   rd_word[0] = actl.adc1_convert;
			REG_ADC1_INPUTSRC:  rd_word[1:0] = actl.adc1_inputsrc;
			REG_DAC_ENA:        rd_word[0] = actl.dac_ena;
			REG_DAC_VALUE:      rd_word[9:0] = actl.dac_value;
			REG_COMP_ENA:       rd_word[0] = actl.comp_ena;
			REG_COMP_NINPUTSRC: rd_word[1:0] = actl.comp_ninputsrc;
			REG_COMP_PINPUTSRC: rd_word[1:0] = actl.comp_pinputsrc;
			REG_COMP_DEST:      rd_word[1:0] = cfg.comp_dest;
			REG_RCOSC_ENA:      rd_word[0] = actl.rcosc_ena;
			REG_RCOSC_DEST:     rd_word[1:0] = cfg.rcosc_dest;
			REG_XTAL_DEST:      rd_word[1:0] = cfg.xtal_dest;
			REG_TRAP_DEST:      rd_word[1:0] = cfg.trap_dest;
			REG_IRQ7_SRC:       rd_word[1:0] = cfg.irq7_src;
			REG_IRQ8_SRC:       rd_word[1:0] = cfg.irq8_src;
			REG_ANALOG_OUT_SEL: rd_word[0] = actl.analog_out_sel;
			REG_OPAMP_BIAS_ENA: rd_word[0] = actl.opamp_bias_ena;
			REG_OPAMP_ENA:      rd_word[0] = actl.opamp_ena;
			REG_BG_ENA:         rd_word[0] = actl.bg_ena;
			REG_OVERTEMP_ENA:   rd_word[0] = actl.overtemp_ena;
			REG_OVERTEMP:       rd_word[0] = stat.overtemp;
			REG_OVERTEMP_DEST:  rd_word[1:0] = cfg.overtemp_dest;
			default:            rd_word = '0;
		endcase
	end

	// Control registers, written at the acknowledge edge
	always_ff @(posedge clk) begin
		if (!resetn) begin
			io_ready     <= 1'b0;
			cfg          <= '0;
			// All pads start as inputs
			cfg.gpio_oeb <= '1;
			actl         <= '0;
		end else begin
			io_ready <= ack;
			if (ack) begin
				case (io_req.offset)
					// GPIO, bytes 0 and 1
					REG_GPIO_DATA: cfg.gpio <= 16'(bmerge(cfg.gpio, io_req));
					REG_GPIO_OEB:  cfg.gpio_oeb <= 16'(bmerge(cfg.gpio_oeb, io_req));
					REG_GPIO_PU:   cfg.gpio_pu <= 16'(bmerge(cfg.gpio_pu, io_req));
					REG_GPIO_PD:   cfg.gpio_pd <= 16'(bmerge(cfg.gpio_pd, io_req));
					// ADC control
					REG_ADC0_ENA:
						actl.adc0_ena <= 1'(bmerge(actl.adc0_ena, io_req));
					REG_ADC0_CONVERT:
						actl.adc0_convert <= 1'(bmerge(actl.adc0_convert, io_req));
					REG_ADC0_INPUTSRC:
						actl.adc0_inputsrc <= 2'(bmerge(actl.adc0_inputsrc, io_req));
					REG_ADC1_ENA:
						actl.adc1_ena <= 1'(bmerge(actl.adc1_ena, io_req));
					REG_ADC1_CONVERT:
						actl.adc1_convert <= 1'(bmerge(actl.adc1_convert, io_req));
					REG_ADC1_INPUTSRC:
						actl.adc1_inputsrc <= 2'(bmerge(actl.adc1_inputsrc, io_req));
					// DAC value spans bytes 0 and 1
					REG_DAC_ENA:
						actl.dac_ena <= 1'(bmerge(actl.dac_ena, io_req));
					REG_DAC_VALUE:
						actl.dac_value <= 10'(bmerge(actl.dac_value, io_req));
					// Comparator
					REG_COMP_ENA:
						actl.comp_ena <= 1'(bmerge(actl.comp_ena, io_req));
					REG_COMP_NINPUTSRC:
						actl.comp_ninputsrc <= 2'(bmerge(actl.comp_ninputsrc, io_req));
					REG_COMP_PINPUTSRC:
						actl.comp_pinputsrc <= 2'(bmerge(actl.comp_pinputsrc, io_req));
					REG_COMP_DEST:
						cfg.comp_dest <= 2'(bmerge(cfg.comp_dest, io_req));
					// Oscillators, trap, irq sources
					REG_RCOSC_ENA:
						actl.rcosc_ena <= 1'(bmerge(actl.rcosc_ena, io_req));
					REG_RCOSC_DEST:
						cfg.rcosc_dest <= 2'(bmerge(cfg.rcosc_dest, io_req));
					REG_XTAL_DEST:
						cfg.xtal_dest <= 2'(bmerge(cfg.xtal_dest, io_req));
					REG_TRAP_DEST:
						cfg.trap_dest <= 2'(bmerge(cfg.trap_dest, io_req));
					REG_IRQ7_SRC:
						cfg.irq7_src <= 2'(bmerge(cfg.irq7_src, io_req));
					REG_IRQ8_SRC:
						cfg.irq8_src <= 2'(bmerge(cfg.irq8_src, io_req));
					// Analog output path
					REG_ANALOG_OUT_SEL:
						actl.analog_out_sel <= 1'(bmerge(actl.analog_out_sel, io_req));
					REG_OPAMP_BIAS_ENA:
						actl.opamp_bias_ena <= 1'(bmerge(actl.opamp_bias_ena, io_req));
					REG_OPAMP_ENA:
						actl.opamp_ena <= 1'(bmerge(actl.opamp_ena, io_req));
					REG_BG_ENA:
						actl.bg_ena <= 1'(bmerge(actl.bg_ena, io_req));
					// Over-temperature alarm
					REG_OVERTEMP_ENA:
						actl.overtemp_ena <= 1'(bmerge(actl.overtemp_ena, io_req));
					REG_OVERTEMP_DEST:
						cfg.overtemp_dest <= 2'(bmerge(cfg.overtemp_dest, io_req));
					// Read-only and unmapped offsets
					default: ;
				endcase
			end
		end
	end

	// Read data captured with the acknowledge
	always_ff @(posedge clk) begin
		if (ack) begin
			io_rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

// ==== source/pin_mux.sv ====
// GPIO output routing and interrupt vector assembly
// Internal signals override pads, pad controls masked while routed
`default_nettype none

module pin_mux import raven_io_pkg::*; (
	input  route_cfg_t   cfg,
	input  analog_stat_t stat,
	input  logic         trap,
	input  logic [15:0]  gpio_in,
	input  logic         irq_pin,
	input  logic         irq_spi,
	output pad_out_t     pads,
	output word_t        irq
);

	logic [15:0] keep;

	// Interrupt source select, 0 disables
	function automatic logic pick(input logic [1:0] src, input logic [2:0] taps);
		case (src)
			2'd1:    return taps[0];
			2'd2:    return taps[1];
			2'd3:    return taps[2];
			default: return 1'b0;
		endcase
	endfunction

	// Pad controls pass only while the group is not routed
	// GPIO 8 to 10 have no internal source
	assign keep = {
		{2{cfg.overtemp_dest == 2'd0}},
		{3{cfg.trap_dest == 2'd0}},
		3'b111,
		{3{cfg.xtal_dest == 2'd0}},
		{3{cfg.rcosc_dest == 2'd0}},
		{2{cfg.comp_dest == 2'd0}}
	};

	assign pads.gpio_outenb   = cfg.gpio_oeb & keep;
	assign pads.gpio_pullup   = cfg.gpio_pu & keep;
	assign pads.gpio_pulldown = cfg.gpio_pd & keep;

	// Output data, destination n selects pin n-1 of the group
	always_comb begin
		pads.gpio_out = cfg.gpio;
		for (int i = 0; i < 2; i++) begin
			// Comparator dest 3 goes to irq, not a pin
			if (cfg.comp_dest == 2'(i + 1))
				pads.gpio_out[i] = stat.comp_in;
			if (cfg.overtemp_dest == 2'(i + 1))
				pads.gpio_out[14 + i] = stat.overtemp;
		end
		for (int i = 0; i < 3; i++) begin
			if (cfg.rcosc_dest == 2'(i + 1))
				pads.gpio_out[2 + i] = stat.rcosc_in;
			if (cfg.xtal_dest == 2'(i + 1))
				pads.gpio_out[5 + i] = stat.xtal_in;
			if (cfg.trap_dest == 2'(i + 1))
				pads.gpio_out[11 + i] = trap;
		end
	end

	// Interrupt vector, unused bits stay low
	always_comb begin
		irq     = '0;
		irq[5]  = irq_pin;
		irq[6]  = irq_spi;
		irq[7]  = pick(cfg.irq7_src, gpio_in[2:0]);
		irq[8]  = pick(cfg.irq8_src, gpio_in[5:3]);
		irq[9]  = (cfg.comp_dest == 2'd3) && stat.comp_in;
		irq[10] = (cfg.overtemp_dest == 2'd3) && stat.overtemp;
	end

endmodule

`default_nettype wire

// ==== source/raven_io.sv ====
// Memory-mapped I/O top level
// Bus decode, register bank and pad routing
`default_nettype none

module raven_io import raven_io_pkg::*; #(
	parameter int MEM_WORDS = 1024
) (
	input  logic         clk,
	input  logic         resetn,
	input  bus_req_t     req,
	input  word_t        ram_rdata,
	input  analog_stat_t stat,
	input  logic         trap,
	input  logic [15:0]  gpio_in,
	input  logic         irq_pin,
	input  logic         irq_spi,
	output logic         mem_ready,
	output word_t        mem_rdata,
	output logic         ram_wenb,
	output logic [9:0]   ram_addr,
	output word_t        ram_wdata,
	output analog_ctrl_t actl,
	output pad_out_t     pads,
	output word_t        irq
);

	// Decode to register bank
	io_req_t    io_req;
	logic       io_ready;
	word_t      io_rdata;
	// Register state for pad routing
	route_cfg_t cfg;

	bus_decode #(
		.MEM_WORDS (MEM_WORDS)
	) u_decode (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.io_ready  (io_ready),
		.io_rdata  (io_rdata),
		.ram_rdata (ram_rdata),
		.io_req    (io_req),
		.ram_wenb  (ram_wenb),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata)
	);

	// GPIO data reads back the routed pad value
	io_reg_bank u_regs (
		.clk      (clk),
		.resetn   (resetn),
		.io_req   (io_req),
		.stat     (stat),
		.gpio_out (pads.gpio_out),
		.gpio_in  (gpio_in),
		.io_ready (io_ready),
		.io_rdata (io_rdata),
		.cfg      (cfg),
		.actl     (actl)
	);

	pin_mux u_pins (
		.cfg     (cfg),
		.stat    (stat),
		.trap    (trap),
		.gpio_in (gpio_in),
		.irq_pin (irq_pin),
		.irq_spi (irq_spi),
		.pads    (pads),
		.irq     (irq)
	);

endmodule

`default_nettype wire

// ==== source/raven_io_pkg.sv ====
// Shared types and constants for the memory-mapped I/O block
// Address views, register offsets, bus request and pad bundles
`default_nettype none

package raven_io_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;

	// RAM window view of a bus address
	typedef struct packed {
		logic [19:0] upper;
		logic [9:0]  word_idx;
		logic [1:0]  byte_off;
	} ram_view_t;

	// I/O page view of the same address
	typedef struct packed {
		logic [23:0] page;
		logic [7:0]  offset;
	} io_view_t;

	typedef union packed {
		ram_view_t ram;
		io_view_t  io;
	} bus_addr_u;

	// Page of the register window, 0x0300_00xx
	localparam logic [23:0] IO_PAGE = 24'h030000;

	// GPIO block
	localparam logic [7:0] REG_GPIO_DATA      = 8'h00;
	localparam logic [7:0] REG_GPIO_OEB       = 8'h04;
	localparam logic [7:0] REG_GPIO_PU        = 8'h08;
	localparam logic [7:0] REG_GPIO_PD        = 8'h0c;
	// ADC0, data and done are read-only
	localparam logic [7:0] REG_ADC0_ENA       = 8'h10;
	localparam logic [7:0] REG_ADC0_DATA      = 8'h14;
	localparam logic [7:0] REG_ADC0_DONE      = 8'h18;
	localparam logic [7:0] REG_ADC0_CONVERT   = 8'h1c;
	localparam logic [7:0] REG_ADC0_INPUTSRC  = 8'h24;
	// ADC1
	localparam logic [7:0] REG_ADC1_ENA       = 8'h30;
	localparam logic [7:0] REG_ADC1_DATA      = 8'h34;
	localparam logic [7:0] REG_ADC1_DONE      = 8'h38;
	localparam logic [7:0] REG_ADC1_CONVERT   = 8'h3c;
	localparam logic [7:0] REG_ADC1_INPUTSRC  = 8'h44;
	// DAC and comparator
	localparam logic [7:0] REG_DAC_ENA        = 8'h50;
	localparam logic [7:0] REG_DAC_VALUE      = 8'h54;
	localparam logic [7:0] REG_COMP_ENA       = 8'h60;
	localparam logic [7:0] REG_COMP_NINPUTSRC = 8'h64;
	localparam logic [7:0] REG_COMP_PINPUTSRC = 8'h68;
	localparam logic [7:0] REG_COMP_DEST      = 8'h6c;
	// Oscillators, trap and interrupt sources
	localparam logic [7:0] REG_RCOSC_ENA      = 8'h70;
	localparam logic [7:0] REG_RCOSC_DEST     = 8'h74;
	localparam logic [7:0] REG_XTAL_DEST      = 8'ha0;
	localparam logic [7:0] REG_TRAP_DEST      = 8'ha8;
	localparam logic [7:0] REG_IRQ7_SRC       = 8'hb0;
	localparam logic [7:0] REG_IRQ8_SRC       = 8'hb4;
	// Analog output path
	localparam logic [7:0] REG_ANALOG_OUT_SEL = 8'hc0;
	localparam logic [7:0] REG_OPAMP_BIAS_ENA = 8'hc4;
	localparam logic [7:0] REG_OPAMP_ENA      = 8'hc8;
	localparam logic [7:0] REG_BG_ENA         = 8'hd0;
	// Over-temperature alarm, level is read-only
	localparam logic [7:0] REG_OVERTEMP_ENA   = 8'he0;
	localparam logic [7:0] REG_OVERTEMP       = 8'he4;
	localparam logic [7:0] REG_OVERTEMP_DEST  = 8'he8;

	typedef struct packed {
		logic      valid;
		bus_addr_u addr;
		word_t     wdata;
		strb_t     wstrb;
	} bus_req_t;

	typedef struct packed {
		logic       sel;
		logic [7:0] offset;
		word_t      wdata;
		strb_t      wstrb;
	} io_req_t;

	typedef struct packed {
		logic [15:0] gpio;
		logic [15:0] gpio_oeb;
		logic [15:0] gpio_pu;
		logic [15:0] gpio_pd;
		logic [1:0]  comp_dest;
		logic [1:0]  rcosc_dest;
		logic [1:0]  xtal_dest;
		logic [1:0]  trap_dest;
		logic [1:0]  overtemp_dest;
		logic [1:0]  irq7_src;
		logic [1:0]  irq8_src;
	} route_cfg_t;

	typedef struct packed {
		logic       adc0_ena;
		logic       adc0_convert;
		logic [1:0] adc0_inputsrc;
		logic       adc1_ena;
		logic       adc1_convert;
		logic [1:0] adc1_inputsrc;
		logic       dac_ena;
		logic [9:0] dac_value;
		logic       comp_ena;
		logic [1:0] comp_ninputsrc;
		logic [1:0] comp_pinputsrc;
		logic       rcosc_ena;
		logic       analog_out_sel;
		logic       opamp_ena;
		logic       opamp_bias_ena;
		logic       bg_ena;
		logic       overtemp_ena;
	} analog_ctrl_t;

	typedef struct packed {
		logic [9:0] adc0_data;
		logic [9:0] adc1_data;
		logic       adc0_done;
		logic       adc1_done;
		logic       comp_in;
		logic       rcosc_in;
		logic       xtal_in;
		logic       overtemp;
	} analog_stat_t;

	typedef struct packed {
		logic [15:0] gpio_out;
		logic [15:0] gpio_outenb;
		logic [15:0] gpio_pullup;
		logic [15:0] gpio_pulldown;
	} pad_out_t;

endpackage

`default_nettype wire
